// ==== tb.f ====
hw/btb_pkg.sv
hw/btb_array.sv
hw/btb_lookup.sv
hw/btb_update.sv
hw/btb_cfg.sv
hw/btb_top.sv
dv/tb_clk_gen.sv
dv/tb_btb.sv

// ==== Bender.yml ====
package:
  name: btb

sources:
  - files:
      - hw/btb_pkg.sv
      - hw/btb_array.sv
      - hw/btb_lookup.sv
      - hw/btb_update.sv
      - hw/btb_cfg.sv
      - hw/btb_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_btb.sv

// ==== dv/tb_btb.sv ====
module tb_btb;

    // Six short tests take well under 1500 cycles
    localparam int max_cycles = 3000;

    logic        clk;
    logic        rst_n;
    logic        lookup_valid;
    logic [31:0] lookup_pc;
    logic        pred_valid;
    logic        pred_hit;
    logic [31:0] pred_target;
    logic        pred_taken;
    logic        update_valid;
    logic [31:0] update_pc;
    logic [31:0] update_target;
    logic        update_taken;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Reference model of the buffer
    logic        m_valid [8][2];
    logic [26:0] m_tag [8][2];
    logic [31:0] m_target [8][2];
    int          m_ctr [8][2];
    int          m_lru [8];
    logic        m_enable;
    int          m_hits;
    int          m_misses;

    // Expected prediction
    // exp is set with the lookup and chk one cycle later
    logic        exp_hit;
    logic [31:0] exp_target;
    logic        exp_taken;
    logic        chk_hit;
    logic [31:0] chk_target;
    logic        chk_taken;
    logic        exp_err;
    logic [31:0] exp_rdata;

    string       test_name;
    int          errors;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;
    int          cycles;
    integer      seed;
    logic [31:0] pc [5];

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    btb_top dut_i (.*);

    // Prediction exactly one cycle after each lookup and at no other time
    pred_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        pred_valid == $past(lookup_valid))
        else begin
            errors++;
            $display("%s: pred_valid does not follow lookup_valid by one cycle", test_name);
        end

    pred_hit_a: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_valid |=> pred_hit == chk_hit)
        else begin
            errors++;
            $display("** Error %s: pred_hit expected %0b actual %0b",
                     test_name, chk_hit, $sampled(pred_hit));
        end

    pred_target_a: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_valid |=> pred_target == chk_target)
        else begin
            errors++;
            $display("** Error %s: pred_target expected %h actual %h",
                     test_name, chk_target, $sampled(pred_target));
        end

    pred_taken_a: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_valid |=> pred_taken == chk_taken)
        else begin
            errors++;
            $display("** Error %s: pred_taken expected %0b actual %0b",
                     test_name, chk_taken, $sampled(pred_taken));
        end

    // APB response in the access phase
    pslverr_a: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable |-> pready && pslverr == exp_err)
        else begin
            errors++;
            $display("** Error %s: pslverr expected %0b actual %0b",
                     test_name, exp_err, $sampled(pslverr));
        end

    prdata_a: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable && !pwrite |-> prdata == exp_rdata)
        else begin
            errors++;
            $display("** Error %s: prdata expected %h actual %h",
                     test_name, exp_rdata, $sampled(prdata));
        end

    // On the next falling edge the expected prediction moves one stage on
    task automatic tick();
        @(negedge clk);
        chk_hit      = exp_hit;
        chk_target   = exp_target;
        chk_taken    = exp_taken;
        lookup_valid = 1'b0;
        update_valid = 1'b0;
    endtask

    task automatic lookup(input logic [31:0] addr);
        int idx;
        tick();
        lookup_valid = 1'b1;
        lookup_pc    = addr;
        idx          = addr[4:2];
        exp_hit      = 1'b0;
        exp_target   = '0;
        exp_taken    = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_enable && m_valid[idx][w] && m_tag[idx][w] == addr[31:5]) begin
                exp_hit    = 1'b1;
                exp_target = m_target[idx][w];
                // Upper half of the counter range predicts taken
                exp_taken  = m_ctr[idx][w] >= 2;
            end
        end
        if (exp_hit) begin
            m_hits++;
        end else begin
            m_misses++;
        end
    endtask

    task automatic update(input logic [31:0] addr, input logic [31:0] target,
                          input logic taken);
        int idx;
        int way;
        tick();
        update_valid  = 1'b1;
        update_pc     = addr;
        update_target = target;
        update_taken  = taken;
        idx           = addr[4:2];
        way           = -1;
        // Disabled buffer drops the update
        if (!m_enable) begin
            return;
        end
        for (int w = 0; w < 2; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == addr[31:5]) begin
                way = w;
            end
        end
        // Miss replaces the LRU way starting from strong not taken
        if (way < 0) begin
            way                = m_lru[idx];
            m_valid[idx][way]  = 1'b1;
            m_tag[idx][way]    = addr[31:5];
            m_ctr[idx][way]    = 0;
        end
        m_target[idx][way] = target;
        if (taken && m_ctr[idx][way] < 3) begin
            m_ctr[idx][way]++;
        end
        if (!taken && m_ctr[idx][way] > 0) begin
            m_ctr[idx][way]--;
        end
        m_lru[idx] = 1 - way;
    endtask

    // One APB3 transfer, setup then access
    task automatic apb(input logic write, input logic [3:0] addr, input logic [31:0] data,
                       input logic err, input logic [31:0] rdata);
        tick();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        tick();
        penable   = 1'b1;
        exp_err   = err;
        exp_rdata = rdata;
        if (write && addr == 4'h0) begin
            m_enable = data[0];
            // Flush clears valid and LRU bits of every set
            if (data[1]) begin
                for (int s = 0; s < 8; s++) begin
                    m_valid[s][0] = 1'b0;
                    m_valid[s][1] = 1'b0;
                    m_lru[s]      = 0;
                end
            end
        end
        tick();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        // Room for the last prediction to be checked
        tick();
        tick();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s", test_name);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", max_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [6:0] outcome;
        seed          = 32'hf469;
        lookup_valid  = 1'b0;
        lookup_pc     = '0;
        update_valid  = 1'b0;
        update_pc     = '0;
        update_target = '0;
        update_taken  = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        exp_hit       = 1'b0;
        exp_target    = '0;
        exp_taken     = 1'b0;
        exp_err       = 1'b0;
        exp_rdata     = '0;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        test_name     = "reset";
        m_enable      = 1'b1;
        m_hits        = 0;
        m_misses      = 0;
        for (int s = 0; s < 8; s++) begin
            m_lru[s] = 0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w]  = 1'b0;
                m_tag[s][w]    = '0;
                m_target[s][w] = '0;
                m_ctr[s][w]    = 0;
            end
        end
        // pc[0] in set 1, pc[1..3] share set 5, pc[4] in set 2
        for (int i = 0; i < 5; i++) begin
            pc[i]      = $random(seed);
            pc[i][1:0] = 2'b00;
        end
        pc[0][4:2] = 3'd1;
        pc[1][4:2] = 3'd5;
        pc[2][4:2] = 3'd5;
        pc[3][4:2] = 3'd5;
        pc[4][4:2] = 3'd2;
        wait (rst_n);

        begin_test("empty_then_insert");
        lookup(pc[0]);
        update(pc[0], $random(seed), 1'b1);
        lookup(pc[0]);
        end_test();

        begin_test("counter_saturation");
        // Three taken, then four not taken
        outcome = 7'b1110000;
        for (int i = 6; i >= 0; i--) begin
            update(pc[0], $random(seed), outcome[i]);
            lookup(pc[0]);
        end
        end_test();

        begin_test("lru_replacement");
        for (int i = 1; i < 4; i++) begin
            update(pc[i], $random(seed), $random(seed) % 2 != 0);
        end
        for (int i = 1; i < 4; i++) begin
            lookup(pc[i]);
        end
        end_test();

        begin_test("flush");
        apb(1'b1, 4'h0, 32'h3, 1'b0, '0);
        for (int i = 0; i < 4; i++) begin
            lookup(pc[i]);
        end
        update(pc[0], $random(seed), 1'b0);
        lookup(pc[0]);
        end_test();

        begin_test("enable_gate");
        apb(1'b1, 4'h0, 32'h0, 1'b0, '0);
        apb(1'b0, 4'h0, '0, 1'b0, 32'h0);
        lookup(pc[0]);
        update(pc[4], $random(seed), 1'b1);
        lookup(pc[4]);
        apb(1'b1, 4'h0, 32'h1, 1'b0, '0);
        lookup(pc[0]);
        lookup(pc[4]);
        update(pc[4], $random(seed), 1'b1);
        lookup(pc[4]);
        end_test();

        begin_test("apb_counters");
        apb(1'b0, 4'h4, '0, 1'b0, m_hits);
        apb(1'b0, 4'h8, '0, 1'b0, m_misses);
        apb(1'b1, 4'h4, 32'h55, 1'b1, '0);
        apb(1'b0, 4'hc, '0, 1'b1, '0);
        apb(1'b1, 4'hc, 32'h1, 1'b1, '0);
        apb(1'b0, 4'h0, '0, 1'b0, 32'h1);
        end_test();

        $display("Tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // Free-running clock with a period of 4
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for 10 cycles
    // Released on a falling edge like every other input
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== hw/btb_top.sv ====
module btb_top (
    input  logic                               clk,
    input  logic                               rst_n,
    // Fetch side
    input  logic                               lookup_valid,
    input  logic [btb_pkg::addr_width-1:0]     lookup_pc,
    output logic                               pred_valid,
    output logic                               pred_hit,
    output logic [btb_pkg::addr_width-1:0]     pred_target,
    output logic                               pred_taken,
    // Execute side
    input  logic                               update_valid,
    input  logic [btb_pkg::addr_width-1:0]     update_pc,
    input  logic [btb_pkg::addr_width-1:0]     update_target,
    input  logic                               update_taken,
    // APB3 register port
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [btb_pkg::apb_addr_width-1:0] paddr,
    input  logic [btb_pkg::apb_data_width-1:0] pwdata,
    output logic [btb_pkg::apb_data_width-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr
);

    logic [btb_pkg::index_width-1:0] lookup_index;
    logic [btb_pkg::set_width-1:0]   lookup_set;
    logic [btb_pkg::index_width-1:0] update_index;
    logic [btb_pkg::set_width-1:0]   update_set;
    logic                            update_lru;
    logic                            wr_en;
    logic [btb_pkg::index_width-1:0] wr_index;
    logic [btb_pkg::set_width-1:0]   wr_set;
    logic                            wr_lru;
    logic                            enable;
    logic                            flush;
    logic                            hit_event;
    logic                            miss_event;

    // Storage with two read ports and one write port
    btb_array array_i (.*);

    // Fetch-side compare and prediction register
    btb_lookup lookup_i (.*);

    // Execute-side merge into the set
    btb_update update_i (.*);

    // Enable, flush and statistics
    btb_cfg cfg_i (.*);

endmodule

// ==== hw/btb_cfg.sv ====
module btb_cfg (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [btb_pkg::apb_addr_width-1:0] paddr,
    input  logic [btb_pkg::apb_data_width-1:0] pwdata,
    output logic [btb_pkg::apb_data_width-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic                               enable,
    output logic                               flush,
    input  logic                               hit_event,
    input  logic                               miss_event
);

    logic                          access;
    logic                          addr_known;
    logic                          addr_counter;
    logic                          ctrl_write;
    logic [btb_pkg::cnt_width-1:0] hit_cnt;
    logic [btb_pkg::cnt_width-1:0] miss_cnt;

    // Zero wait states
    // Access phase is the second cycle
    assign pready = 1'b1;
    assign access = psel && penable;

    // Address decode
    assign addr_counter = (paddr == btb_pkg::reg_hits) || (paddr == btb_pkg::reg_misses);
    assign addr_known   = (paddr == btb_pkg::reg_ctrl) || addr_counter;
    assign ctrl_write   = access && pwrite && (paddr == btb_pkg::reg_ctrl);

    // Error on unknown address or write to a read-only counter
    assign pslverr = access && (!addr_known || (pwrite && addr_counter));

    // Read mux with unknown addresses reading as zero
    always_comb begin
        prdata = '0;
        case (paddr)
            btb_pkg::reg_ctrl:   prdata[0] = enable;
            btb_pkg::reg_hits:   prdata[btb_pkg::cnt_width-1:0] = hit_cnt;
            btb_pkg::reg_misses: prdata[btb_pkg::cnt_width-1:0] = miss_cnt;
            default:             prdata = '0;
        endcase
    end

    // Enable comes out of reset set
    // Flush bit is a command and reads back as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b1;
            flush  <= 1'b0;
        end else begin
            flush <= ctrl_write && pwdata[1];
            if (ctrl_write) begin
                enable <= pwdata[0];
            end
        end
    end

    // Saturating statistics counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_cnt  <= '0;
            miss_cnt <= '0;
        end else begin
            if (hit_event && !(&hit_cnt)) hit_cnt <= hit_cnt + 1'b1;
            if (miss_event && !(&miss_cnt)) miss_cnt <= miss_cnt + 1'b1;
        end
    end

    // APB setup phase between accesses keeps flush to one cycle
    flush_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !flush
    );

endmodule

// ==== hw/btb_update.sv ====
module btb_update (
    input  logic                            enable,
    input  logic                            update_valid,
    input  logic [btb_pkg::addr_width-1:0]  update_pc,
    input  logic [btb_pkg::addr_width-1:0]  update_target,
    input  logic                            update_taken,
    output logic [btb_pkg::index_width-1:0] update_index,
    input  logic [btb_pkg::set_width-1:0]   update_set,
    input  logic                            update_lru,
    output logic                            wr_en,
    output logic [btb_pkg::index_width-1:0] wr_index,
    output logic [btb_pkg::set_width-1:0]   wr_set,
    output logic                            wr_lru
);

    logic [btb_pkg::tag_width-1:0] update_tag;
    btb_pkg::way_t                 rd_way [btb_pkg::num_ways];
    btb_pkg::way_t                 wr_way [btb_pkg::num_ways];
    logic [btb_pkg::num_ways-1:0]  match;
    logic [btb_pkg::num_ways-1:0]  take;
    logic                          insert;

    // Saturating two-bit step by the resolved direction
    function automatic btb_pkg::ctr_state_e ctr_step(
        input btb_pkg::ctr_state_e cur,
        input logic                taken
    );
        btb_pkg::ctr_state_e nxt;
        unique case (cur)
            btb_pkg::strong_not_taken:
                nxt = taken ? btb_pkg::weak_not_taken : btb_pkg::strong_not_taken;
            btb_pkg::weak_not_taken:
                nxt = taken ? btb_pkg::weak_taken : btb_pkg::strong_not_taken;
            btb_pkg::weak_taken:
                nxt = taken ? btb_pkg::strong_taken : btb_pkg::weak_not_taken;
            default:
                nxt = taken ? btb_pkg::strong_taken : btb_pkg::weak_taken;
        endcase
        return nxt;
    endfunction

    assign update_index = update_pc[btb_pkg::tag_lsb-1:btb_pkg::index_lsb];
    assign update_tag   = update_pc[btb_pkg::addr_width-1:btb_pkg::tag_lsb];

    // Unpack the set and look for the branch
    always_comb begin
        for (int w = 0; w < btb_pkg::num_ways; w++) begin
            rd_way[w] = update_set[btb_pkg::set_width - 1 - w * btb_pkg::way_width
                                   -: btb_pkg::way_width];
            match[w]  = rd_way[w].valid && (rd_way[w].tag == update_tag);
        end
    end

    // No matching way means a new entry in the LRU way
    assign insert = !(|match);

    // Choose the way and build the new set
    always_comb begin
        for (int w = 0; w < btb_pkg::num_ways; w++) begin
            take[w]   = match[w] || (insert && (update_lru == 1'(w)));
            // Untouched way is passed through as read
            wr_way[w] = rd_way[w];
            if (take[w]) begin
                wr_way[w].valid  = 1'b1;
                // Equal to the stored tag on a refresh
                wr_way[w].tag    = update_tag;
                wr_way[w].target = update_target;
                // New entries start strong not taken, then step once
                wr_way[w].ctr    = ctr_step(insert ? btb_pkg::strong_not_taken
                                                   : rd_way[w].ctr, update_taken);
                wr_way[w].spare  = '0;
            end
            wr_set[btb_pkg::set_width - 1 - w * btb_pkg::way_width
                   -: btb_pkg::way_width] = wr_way[w];
        end
    end

    // LRU then names the way that was not written
    assign wr_lru   = take[0];
    assign wr_index = update_index;
    assign wr_en    = update_valid && enable;

    // Exactly one way receives the branch
    one_way_a: assert final (!wr_en || $onehot(take));

endmodule

// ==== hw/btb_lookup.sv ====
module btb_lookup (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            enable,
    input  logic                            lookup_valid,
    input  logic [btb_pkg::addr_width-1:0]  lookup_pc,
    output logic [btb_pkg::index_width-1:0] lookup_index,
    input  logic [btb_pkg::set_width-1:0]   lookup_set,
    output logic                            pred_valid,
    output logic                            pred_hit,
    output logic [btb_pkg::addr_width-1:0]  pred_target,
    output logic                            pred_taken,
    output logic                            hit_event,
    output logic                            miss_event
);

    logic [btb_pkg::tag_width-1:0]  lookup_tag;
    btb_pkg::way_t                  rd_way [btb_pkg::num_ways];
    logic [btb_pkg::num_ways-1:0]   match;
    logic                           hit;
    logic [btb_pkg::addr_width-1:0] hit_target;
    logic                           hit_taken;

    // Address split into set index and tag
    assign lookup_index = lookup_pc[btb_pkg::tag_lsb-1:btb_pkg::index_lsb];
    assign lookup_tag   = lookup_pc[btb_pkg::addr_width-1:btb_pkg::tag_lsb];

    // Compare the tag on every way and pick the matching one
    always_comb begin
        hit_target = '0;
        hit_taken  = 1'b0;
        for (int w = 0; w < btb_pkg::num_ways; w++) begin
            rd_way[w] = lookup_set[btb_pkg::set_width - 1 - w * btb_pkg::way_width
                                   -: btb_pkg::way_width];
            match[w]  = rd_way[w].valid && (rd_way[w].tag == lookup_tag);
            if (match[w]) begin
                hit_target = rd_way[w].target;
                // Taken states have the upper counter bit set
                hit_taken  = rd_way[w].ctr[1];
            end
        end
    end

    // A disabled buffer still answers, always with a miss
    assign hit = enable && (|match);

    // Control flags of the prediction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
            pred_hit   <= 1'b0;
        end else begin
            pred_valid <= lookup_valid;
            pred_hit   <= lookup_valid && hit;
        end
    end

    // Prediction payload is zero on a miss
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            pred_target <= hit ? hit_target : '0;
            pred_taken  <= hit && hit_taken;
        end
    end

    // Statistics pulses line up with the prediction
    assign hit_event  = pred_valid && pred_hit;
    assign miss_event = pred_valid && !pred_hit;

    // Update merge must never leave one tag in two ways
    one_match_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        lookup_valid |-> !(&match)
    );

    // Every lookup is counted exactly once, on the next cycle
    one_event_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        lookup_valid |=> pred_valid && (hit_event != miss_event)
    );

endmodule

// ==== hw/btb_array.sv ====
module btb_array (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            flush,
    input  logic [btb_pkg::index_width-1:0] lookup_index,
    output logic [btb_pkg::set_width-1:0]   lookup_set,
    input  logic [btb_pkg::index_width-1:0] update_index,
    output logic [btb_pkg::set_width-1:0]   update_set,
    output logic                            update_lru,
    input  logic                            wr_en,
    input  logic [btb_pkg::index_width-1:0] wr_index,
    input  logic [btb_pkg::set_width-1:0]   wr_set,
    input  logic                            wr_lru
);

    // Set storage, one row per index
    logic [btb_pkg::set_width-1:0] sets [btb_pkg::num_sets];

    // One LRU bit per set
    // Value names the way to replace next
    logic [btb_pkg::num_sets-1:0] lru;

    // Two independent read ports without read latency
    assign lookup_set = sets[lookup_index];
    assign update_set = sets[update_index];
    assign update_lru = lru[update_index];

    // Only valid bits and LRU bits are cleared
    // Tag, target and counter stay as they were
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int s = 0; s < btb_pkg::num_sets; s++) begin
                for (int w = 0; w < btb_pkg::num_ways; w++) begin
                    // Valid is the top bit of each way
                    sets[s][(w + 1) * btb_pkg::way_width - 1] <= 1'b0;
                end
            end
            lru <= '0;
        end else if (wr_en) begin
            // Whole set is rewritten by the update path
            sets[wr_index] <= wr_set;
            lru[wr_index]  <= wr_lru;
        end
    end

    // Write address from the update merge must be resolved
    wr_index_known_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_index)
    );

endmodule

// ==== hw/btb_pkg.sv ====
package btb_pkg;

    // Buffer geometry
    localparam int num_sets    = 8;
    localparam int num_ways    = 2;
    localparam int index_width = 3;
    localparam int tag_width   = 27;
    localparam int addr_width  = 32;

    // Word offset below the index field of a fetch address
    localparam int index_lsb = 2;
    localparam int tag_lsb   = index_lsb + index_width;

    // One way is 64 bits
    // A set holds both ways with way 0 on top
    localparam int way_width = 64;
    localparam int set_width = num_ways * way_width;

    // Hit and miss counters saturate at all ones
    localparam int cnt_width = 16;

    // APB register port widths
    localparam int apb_addr_width = 4;
    localparam int apb_data_width = 32;

    // Two-bit direction counter
    // Upper bit set means the way predicts taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_state_e;

    // Register map of the configuration block
    typedef enum logic [apb_addr_width-1:0] {
        reg_ctrl   = 4'h0,
        reg_hits   = 4'h4,
        reg_misses = 4'h8
    } apb_reg_e;

    // Stored way, MSB first
    // valid, tag, target, counter, two spare bits
    typedef struct packed {
        logic                  valid;
        logic [tag_width-1:0]  tag;
        logic [addr_width-1:0] target;
        ctr_state_e            ctr;
        logic [1:0]            spare;
    } way_t;

endpackage
